// ==== csi2_byte_tx_top.f ====
verilog/csi2_pkg.sv
verilog/frame_event_detect.sv
verilog/raw10_packer.sv
verilog/packet_header_ctrl.sv
verilog/csi2_crc16.sv
verilog/csi2_packet_serializer.sv
verilog/csi2_byte_tx_top.sv
tb/csi2_byte_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CSI-2 byte transmitter testbench with Verilator and runs it.
# The exit status of the simulation binary is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
    --top-module csi2_byte_tx_tb \
    -f csi2_byte_tx_top.f \
    --Mdir obj_dir \
    -o csi2_byte_tx_sim

./obj_dir/csi2_byte_tx_sim

// ==== tb/csi2_byte_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi2_byte_tx_tb;

    import csi2_pkg::*;

    localparam int LINES_PER_FRAME = 4;
    localparam int FRAME_COUNT     = 3;
    localparam int SEED            = 68;
    localparam int RUN_LIMIT       = 6000;
    localparam int DRAIN_LIMIT     = 400;

    // packet sizes from the csi-2 framing and the raw10 packing rule
    localparam int SHORT_BYTES = 4;
    localparam int LINE_BYTES  = 4 + IMAGE_X_SIZE / 4 * 5 + 2;
    localparam int TOTAL_BYTES = FRAME_COUNT * (2 * SHORT_BYTES + LINES_PER_FRAME * LINE_BYTES);
    localparam int TOTAL_ENDS  = FRAME_COUNT * (2 + LINES_PER_FRAME);

    // parity column of each header bit with p0 in the lsb
    localparam logic [5:0] ECC_COLUMN [24] = '{
        6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
        6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
        6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
    };

    logic                   clock_camera_byte;
    logic                   reset_camera_byte_n;
    logic                   pixel_valid_i;
    logic [PIXEL_WIDTH-1:0] pixel_data_i;
    logic                   frame_valid_i;
    logic                   line_valid_i;
    logic                   tx_byte_valid_o;
    logic [7:0]             tx_byte_o;
    logic                   tx_packet_end_o;

    logic [7:0]             exp_bytes [$];
    logic                   exp_ends [$];
    string                  exp_tags [$];
    logic [PIXEL_WIDTH-1:0] line_pix [IMAGE_X_SIZE];
    int                     act_byte_total;
    int                     act_end_total;
    int                     frame_idx;
    int                     line_idx;

    csi2_byte_tx_top uut (
        .clock_camera_byte  (clock_camera_byte),
        .reset_camera_byte_n(reset_camera_byte_n),
        .pixel_valid_i      (pixel_valid_i),
        .pixel_data_i       (pixel_data_i),
        .frame_valid_i      (frame_valid_i),
        .line_valid_i       (line_valid_i),
        .tx_byte_valid_o    (tx_byte_valid_o),
        .tx_byte_o          (tx_byte_o),
        .tx_packet_end_o    (tx_packet_end_o)
    );

    initial begin
        clock_camera_byte = 1'b0;
        forever #20 clock_camera_byte = ~clock_camera_byte;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [7:0] header_ecc(input logic [23:0] hdr);
        logic [5:0] p;
        p = 6'd0;
        for (int i = 0; i < 24; i++) begin
            if (hdr[i]) begin
                p = p ^ ECC_COLUMN[i];
            end
        end
        return {2'b00, p};
    endfunction

    // reflected 0x1021 applied lsb first
    function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) begin
                c = (c >> 1) ^ 16'h8408;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic push_expected(input logic [7:0] b, input logic is_end, input string tag);
        exp_bytes.push_back(b);
        exp_ends.push_back(is_end);
        exp_tags.push_back(tag);
    endtask

    task automatic model_header(input logic [5:0] dt, input logic [15:0] wc,
                                input logic ends_here, input string tag);
        logic [7:0] di;
        di = {VIRTUAL_CHANNEL, dt};
        push_expected(di, 1'b0, {tag, " data id"});
        push_expected(wc[7:0], 1'b0, {tag, " word count low"});
        push_expected(wc[15:8], 1'b0, {tag, " word count high"});
        push_expected(header_ecc({wc, di}), ends_here, {tag, " ecc"});
    endtask

    task automatic model_line_packet();
        logic [7:0]  payload [$];
        logic [15:0] crc;
        string       tag;
        tag = $sformatf("frame %0d line %0d", frame_idx, line_idx);
        for (int g = 0; g < IMAGE_X_SIZE; g += 4) begin
            for (int k = 0; k < 4; k++) begin
                payload.push_back(line_pix[g + k][9:2]);
            end
            payload.push_back({line_pix[g + 3][1:0], line_pix[g + 2][1:0],
                               line_pix[g + 1][1:0], line_pix[g][1:0]});
        end
        model_header(DT_RAW10, 16'(payload.size()), 1'b0, {tag, " header"});
        crc = 16'hFFFF;
        foreach (payload[i]) begin
            crc = crc16_update(crc, payload[i]);
            push_expected(payload[i], 1'b0, $sformatf("%s payload byte %0d", tag, i));
        end
        push_expected(crc[7:0], 1'b0, {tag, " crc low"});
        push_expected(crc[15:8], 1'b1, {tag, " crc high"});
    endtask

    task automatic blank_cycles();
        repeat ($urandom_range(20, 12)) @(negedge clock_camera_byte);
    endtask

    task automatic drive_line();
        for (int k = 0; k < IMAGE_X_SIZE; k++) begin
            line_pix[k] = PIXEL_WIDTH'($urandom);
        end
        model_line_packet();
        line_valid_i = 1'b1;
        for (int k = 0; k < IMAGE_X_SIZE; k++) begin
            repeat ($urandom_range(3, 1)) @(negedge clock_camera_byte);
            pixel_valid_i = 1'b1;
            pixel_data_i  = line_pix[k];
            @(negedge clock_camera_byte);
            pixel_valid_i = 1'b0;
        end
        repeat ($urandom_range(3, 1)) @(negedge clock_camera_byte);
        line_valid_i = 1'b0;
    endtask

    // output monitor samples mid-cycle
    always @(negedge clock_camera_byte) begin : monitor
        logic [7:0] exp_b;
        logic       exp_e;
        string      tag;
        if (tx_packet_end_o && !tx_byte_valid_o) begin
            $display("packet end flagged on a cycle without an output byte");
            abort_run();
        end
        if (tx_byte_valid_o) begin
            if (exp_bytes.size() == 0) begin
                $display("output byte 0x%0h arrived with no packet pending", tx_byte_o);
                abort_run();
            end
            exp_b = exp_bytes.pop_front();
            exp_e = exp_ends.pop_front();
            tag   = exp_tags.pop_front();
            check_equal(tag, 32'(exp_b), 32'(tx_byte_o));
            check_equal({tag, " packet end"}, 32'(exp_e), 32'(tx_packet_end_o));
            act_byte_total++;
            if (tx_packet_end_o) begin
                act_end_total++;
            end
        end
    end

    initial begin
        for (int n = 0; n < RUN_LIMIT; n++) begin
            @(posedge clock_camera_byte);
        end
        $display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
        abort_run();
    end

    initial begin
        int drain;
        reset_camera_byte_n = 1'b0;
        pixel_valid_i       = 1'b0;
        pixel_data_i        = '0;
        frame_valid_i       = 1'b0;
        line_valid_i        = 1'b0;
        act_byte_total      = 0;
        act_end_total       = 0;
        frame_idx           = 0;
        line_idx            = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clock_camera_byte);
        @(negedge clock_camera_byte);
        reset_camera_byte_n = 1'b1;

        for (frame_idx = 0; frame_idx < FRAME_COUNT; frame_idx++) begin
            blank_cycles();
            frame_valid_i = 1'b1;
            model_header(DT_FRAME_START, 16'd0, 1'b1, $sformatf("frame %0d start", frame_idx));
            for (line_idx = 0; line_idx < LINES_PER_FRAME; line_idx++) begin
                blank_cycles();
                drive_line();
            end
            blank_cycles();
            frame_valid_i = 1'b0;
            model_header(DT_FRAME_END, 16'd0, 1'b1, $sformatf("frame %0d end", frame_idx));
        end

        for (drain = 0; drain < DRAIN_LIMIT && exp_bytes.size() != 0; drain++) begin
            @(negedge clock_camera_byte);
        end
        if (exp_bytes.size() != 0) begin
            $display("timeout: %0d expected bytes never appeared", exp_bytes.size());
            abort_run();
        end
        // idle tail for stray bytes
        repeat (40) @(negedge clock_camera_byte);

        check_equal("total byte count", 32'(TOTAL_BYTES), 32'(act_byte_total));
        check_equal("total packet end count", 32'(TOTAL_ENDS), 32'(act_end_total));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/csi2_byte_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi2_byte_tx_top (
    input  wire                             clock_camera_byte,
    input  wire                             reset_camera_byte_n,
    input  wire                             pixel_valid_i,
    input  wire [csi2_pkg::PIXEL_WIDTH-1:0] pixel_data_i,
    input  wire                             frame_valid_i,
    input  wire                             line_valid_i,
    output logic                            tx_byte_valid_o,
    output logic [7:0]                      tx_byte_o,
    output logic                            tx_packet_end_o
);

    import csi2_pkg::*;

    logic        frame_start;
    logic        frame_end;
    logic        line_start;
    logic        payload_valid;
    logic [7:0]  payload_byte;
    logic        header_valid;
    logic        header_long;
    logic [7:0]  header_data_id;
    logic [15:0] header_word_count;
    logic [7:0]  header_ecc;

    frame_event_detect u_frame_event_detect (
        .clock_camera_byte  (clock_camera_byte),
        .reset_camera_byte_n(reset_camera_byte_n),
        .frame_valid_i      (frame_valid_i),
        .line_valid_i       (line_valid_i),
        .frame_start_o      (frame_start),
        .frame_end_o        (frame_end),
        .line_start_o       (line_start)
    );

    raw10_packer u_raw10_packer (
        .clock_camera_byte  (clock_camera_byte),
        .reset_camera_byte_n(reset_camera_byte_n),
        .pixel_valid_i      (pixel_valid_i),
        .pixel_data_i       (pixel_data_i),
        .line_start_i       (line_start),
        .payload_valid_o    (payload_valid),
        .payload_byte_o     (payload_byte)
    );

    packet_header_ctrl u_packet_header_ctrl (
        .clock_camera_byte  (clock_camera_byte),
        .reset_camera_byte_n(reset_camera_byte_n),
        .frame_start_i      (frame_start),
        .frame_end_i        (frame_end),
        .line_start_i       (line_start),
        .header_valid_o     (header_valid),
        .header_long_o      (header_long),
        .header_data_id_o   (header_data_id),
        .header_word_count_o(header_word_count),
        .header_ecc_o       (header_ecc)
    );

    csi2_packet_serializer #(
        .PAYLOAD_FIFO_DEPTH(PAYLOAD_FIFO_DEPTH)
    ) u_packet_serializer (
        .clock_camera_byte  (clock_camera_byte),
        .reset_camera_byte_n(reset_camera_byte_n),
        .header_valid_i     (header_valid),
        .header_long_i      (header_long),
        .header_data_id_i   (header_data_id),
        .header_word_count_i(header_word_count),
        .header_ecc_i       (header_ecc),
        .payload_valid_i    (payload_valid),
        .payload_byte_i     (payload_byte),
        .tx_byte_valid_o    (tx_byte_valid_o),
        .tx_byte_o          (tx_byte_o),
        .tx_packet_end_o    (tx_packet_end_o)
    );

endmodule

`default_nettype wire

// ==== verilog/csi2_crc16.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi2_crc16 (
    input  wire         clock_camera_byte,
    input  wire         reset_camera_byte_n,
    input  wire         crc_clear_i,
    input  wire         crc_valid_i,
    input  wire  [7:0]  crc_byte_i,
    output logic [15:0] crc_value_o
);

    logic [15:0] crc_next;
    logic        feedback;

    // x^16+x^12+x^5+1, reflected, lsb first
    always_comb begin
        crc_next = crc_value_o;
        feedback = 1'b0;
        for (int i = 0; i < 8; i++) begin
            feedback = crc_next[0] ^ crc_byte_i[i];
            crc_next = {1'b0, crc_next[15:1]} ^ (feedback ? 16'h8408 : 16'h0000);
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            crc_value_o <= 16'hFFFF;
        end else if (crc_clear_i) begin
            crc_value_o <= 16'hFFFF;
        end else if (crc_valid_i) begin
            crc_value_o <= crc_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csi2_packet_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi2_packet_serializer #(
    parameter int PAYLOAD_FIFO_DEPTH = csi2_pkg::PAYLOAD_FIFO_DEPTH
) (
    input  wire         clock_camera_byte,
    input  wire         reset_camera_byte_n,
    input  wire         header_valid_i,
    input  wire         header_long_i,
    input  wire  [7:0]  header_data_id_i,
    input  wire  [15:0] header_word_count_i,
    input  wire  [7:0]  header_ecc_i,
    input  wire         payload_valid_i,
    input  wire  [7:0]  payload_byte_i,
    output logic        tx_byte_valid_o,
    output logic [7:0]  tx_byte_o,
    output logic        tx_packet_end_o
);

    localparam int PTR_W = $clog2(PAYLOAD_FIFO_DEPTH);
    localparam int CNT_W = $clog2(PAYLOAD_FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_CRC
    } state_t;

    state_t      state;
    logic [1:0]  hdr_idx;
    logic        crc_idx;
    logic [15:0] pay_cnt;
    logic        hdr_long;
    logic [7:0]  hdr_di;
    logic [15:0] hdr_wc;
    logic [7:0]  hdr_ecc;

    logic [7:0]       fifo_mem [0:PAYLOAD_FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    logic             fifo_pop;
    logic [7:0]       fifo_head;

    logic        crc_clear;
    logic [15:0] crc_value;

    assign fifo_head = fifo_mem[rd_ptr];
    assign fifo_pop  = (state == ST_PAYLOAD) && (fifo_count != '0);
    assign crc_clear = header_valid_i && (state == ST_IDLE);

    always_ff @(posedge clock_camera_byte) begin
        if (payload_valid_i) begin
            fifo_mem[wr_ptr] <= payload_byte_i;
        end
    end

    // circular pointers, wrap at any depth
    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (payload_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(PAYLOAD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(PAYLOAD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({payload_valid_i, fifo_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (crc_clear) begin
            hdr_long <= header_long_i;
            hdr_di   <= header_data_id_i;
            hdr_wc   <= header_word_count_i;
            hdr_ecc  <= header_ecc_i;
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state   <= ST_IDLE;
            hdr_idx <= 2'd0;
            crc_idx <= 1'b0;
            pay_cnt <= 16'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (header_valid_i) begin
                        state   <= ST_HEADER;
                        hdr_idx <= 2'd0;
                    end
                end
                ST_HEADER: begin
                    hdr_idx <= hdr_idx + 2'd1;
                    if (hdr_idx == 2'd3) begin
                        state   <= hdr_long ? ST_PAYLOAD : ST_IDLE;
                        pay_cnt <= 16'd0;
                    end
                end
                ST_PAYLOAD: begin
                    if (fifo_pop) begin
                        pay_cnt <= pay_cnt + 16'd1;
                        if (pay_cnt == hdr_wc - 16'd1) begin
                            state   <= ST_CRC;
                            crc_idx <= 1'b0;
                        end
                    end
                end
                ST_CRC: begin
                    crc_idx <= 1'b1;
                    if (crc_idx) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        tx_byte_valid_o = 1'b0;
        tx_byte_o       = 8'h00;
        tx_packet_end_o = 1'b0;
        case (state)
            ST_HEADER: begin
                tx_byte_valid_o = 1'b1;
                case (hdr_idx)
                    2'd0:    tx_byte_o = hdr_di;
                    2'd1:    tx_byte_o = hdr_wc[7:0];
                    2'd2:    tx_byte_o = hdr_wc[15:8];
                    default: tx_byte_o = hdr_ecc;
                endcase
                // short packet ends on its ecc byte
                tx_packet_end_o = (hdr_idx == 2'd3) && !hdr_long;
            end
            ST_PAYLOAD: begin
                tx_byte_valid_o = fifo_pop;
                tx_byte_o       = fifo_head;
            end
            ST_CRC: begin
                tx_byte_valid_o = 1'b1;
                tx_byte_o       = crc_idx ? crc_value[15:8] : crc_value[7:0];
                tx_packet_end_o = crc_idx;
            end
            default: begin
                tx_byte_valid_o = 1'b0;
            end
        endcase
    end

    csi2_crc16 u_crc16 (
        .clock_camera_byte  (clock_camera_byte),
        .reset_camera_byte_n(reset_camera_byte_n),
        .crc_clear_i        (crc_clear),
        .crc_valid_i        (fifo_pop),
        .crc_byte_i         (fifo_head),
        .crc_value_o        (crc_value)
    );

    a_fifo_overflow: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        payload_valid_i |-> (fifo_count < CNT_W'(PAYLOAD_FIFO_DEPTH)) || fifo_pop
    );

    // header requests only land between packets
    a_header_when_idle: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        header_valid_i |-> state == ST_IDLE
    );

endmodule

`default_nettype wire

// ==== verilog/csi2_pkg.sv ====
`default_nettype none

package csi2_pkg;

    // csi-2 data types
    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW10       = 6'h2B;

    localparam logic [1:0] VIRTUAL_CHANNEL = 2'd0;

    localparam int PIXEL_WIDTH = 10;

    // must be a multiple of 4 pixels
    localparam int IMAGE_X_SIZE = 16;

    // raw10 payload bytes per line
    localparam logic [15:0] WORD_COUNT = 16'(IMAGE_X_SIZE * 10 / 8);

    localparam int PAYLOAD_FIFO_DEPTH = 16;

endpackage

`default_nettype wire

// ==== verilog/frame_event_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_event_detect (
    input  wire  clock_camera_byte,
    input  wire  reset_camera_byte_n,
    input  wire  frame_valid_i,
    input  wire  line_valid_i,
    output logic frame_start_o,
    output logic frame_end_o,
    output logic line_start_o
);

    logic frame_valid_q;
    logic line_valid_q;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            line_start_o  <= 1'b0;
        end else begin
            frame_valid_q <= frame_valid_i;
            line_valid_q  <= line_valid_i;
            frame_start_o <= frame_valid_i & ~frame_valid_q;
            frame_end_o   <= ~frame_valid_i & frame_valid_q;
            // lines only count inside a frame
            line_start_o  <= line_valid_i & ~line_valid_q & frame_valid_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/packet_header_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_header_ctrl (
    input  wire         clock_camera_byte,
    input  wire         reset_camera_byte_n,
    input  wire         frame_start_i,
    input  wire         frame_end_i,
    input  wire         line_start_i,
    output logic        header_valid_o,
    output logic        header_long_o,
    output logic [7:0]  header_data_id_o,
    output logic [15:0] header_word_count_o,
    output logic [7:0]  header_ecc_o
);

    import csi2_pkg::*;

    logic [5:0]  dt_sel;
    logic [15:0] wc_sel;
    logic        long_sel;
    logic [7:0]  di_sel;

    // six-bit hamming parity over {wc, di}, top two bits stay zero
    function automatic logic [7:0] ecc_calc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = ^(d & 24'hF12CB7);
        p[1] = ^(d & 24'hF2555B);
        p[2] = ^(d & 24'h749A6D);
        p[3] = ^(d & 24'hB8E38E);
        p[4] = ^(d & 24'hDF03F0);
        p[5] = ^(d & 24'hEFFC00);
        return {2'b00, p};
    endfunction

    always_comb begin
        dt_sel   = DT_RAW10;
        wc_sel   = WORD_COUNT;
        long_sel = 1'b1;
        if (frame_start_i) begin
            dt_sel   = DT_FRAME_START;
            wc_sel   = 16'd0;
            long_sel = 1'b0;
        end else if (frame_end_i) begin
            dt_sel   = DT_FRAME_END;
            wc_sel   = 16'd0;
            long_sel = 1'b0;
        end
    end

    assign di_sel = {VIRTUAL_CHANNEL, dt_sel};

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            header_valid_o <= 1'b0;
        end else begin
            header_valid_o <= frame_start_i | frame_end_i | line_start_i;
        end
    end

    // header fields hold until the next request
    always_ff @(posedge clock_camera_byte) begin
        if (frame_start_i || frame_end_i || line_start_i) begin
            header_long_o       <= long_sel;
            header_data_id_o    <= di_sel;
            header_word_count_o <= wc_sel;
            header_ecc_o        <= ecc_calc({wc_sel, di_sel});
        end
    end

    a_single_event: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        $onehot0({frame_start_i, frame_end_i, line_start_i})
    );

endmodule

`default_nettype wire

// ==== verilog/raw10_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module raw10_packer (
    input  wire                             clock_camera_byte,
    input  wire                             reset_camera_byte_n,
    input  wire                             pixel_valid_i,
    input  wire [csi2_pkg::PIXEL_WIDTH-1:0] pixel_data_i,
    input  wire                             line_start_i,
    output logic                            payload_valid_o,
    output logic [7:0]                      payload_byte_o
);

    import csi2_pkg::*;

    logic [1:0]             pix_cnt;
    logic [1:0]             grp_idx;
    logic [PIXEL_WIDTH-1:0] pix_store [0:2];
    logic [PIXEL_WIDTH-1:0] out_pix [0:3];
    logic                   seq_active;
    logic [2:0]             seq_idx;

    // a line start realigns the group, even with a pixel in the same cycle
    assign grp_idx = line_start_i ? 2'd0 : pix_cnt;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            pix_cnt <= 2'd0;
        end else if (pixel_valid_i) begin
            pix_cnt <= grp_idx + 2'd1;
        end else if (line_start_i) begin
            pix_cnt <= 2'd0;
        end
    end

    // pixel store and output copy, so the next group can fill meanwhile
    always_ff @(posedge clock_camera_byte) begin
        if (pixel_valid_i) begin
            if (grp_idx == 2'd3) begin
                out_pix[0] <= pix_store[0];
                out_pix[1] <= pix_store[1];
                out_pix[2] <= pix_store[2];
                out_pix[3] <= pixel_data_i;
            end else begin
                pix_store[grp_idx] <= pixel_data_i;
            end
        end
    end

    // five-step output sequencer
    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            seq_active <= 1'b0;
            seq_idx    <= 3'd0;
        end else if (pixel_valid_i && grp_idx == 2'd3) begin
            seq_active <= 1'b1;
            seq_idx    <= 3'd0;
        end else if (seq_active) begin
            if (seq_idx == 3'd4) begin
                seq_active <= 1'b0;
            end
            seq_idx <= seq_idx + 3'd1;
        end
    end

    assign payload_valid_o = seq_active;

    always_comb begin
        if (seq_idx == 3'd4) begin
            // low bit pairs, pixel 0 in the lsbs
            payload_byte_o = {out_pix[3][1:0], out_pix[2][1:0],
                              out_pix[1][1:0], out_pix[0][1:0]};
        end else begin
            payload_byte_o = out_pix[seq_idx[1:0]][PIXEL_WIDTH-1 -: 8];
        end
    end

    a_pixel_spacing: assert property (
        @(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        pixel_valid_i |=> !pixel_valid_i
    );

endmodule

`default_nettype wire
